// ==== all.f ====
+incdir+include
hdl/spi_reg_pkg.sv
hdl/spi_bus_pkg.sv
hdl/spi_sfr_bank.sv
hdl/spi_shift_engine.sv
hdl/spi_dio_bridge.sv
hdl/spi_dio_master.sv
testbench/spi_dio_checker.sv
testbench/tb_spi_dio_master.sv

// ==== Bender.yml ====
package:
  name: spi_dio_master

export_include_dirs:
  - include

sources:
  - hdl/spi_reg_pkg.sv
  - hdl/spi_bus_pkg.sv
  - hdl/spi_sfr_bank.sv
  - hdl/spi_shift_engine.sv
  - hdl/spi_dio_bridge.sv
  - hdl/spi_dio_master.sv
  - target: test
    files:
      - testbench/spi_dio_checker.sv
      - testbench/tb_spi_dio_master.sv

// ==== testbench/tb_spi_dio_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_dio_cfg.svh"

module tb_spi_dio_master;

    localparam int          N_XFER = 10;
    localparam logic [31:0] DATA_A = `SPI_DIO_BASE_ADDR + `SPI_DIO_REG_DATA;
    localparam logic [31:0] CFG_A  = `SPI_DIO_BASE_ADDR + `SPI_DIO_REG_CFG;

    // Transfer table, index 0..2 test 2, 3..5 test 3, 6..7 test 4, 8 and 9 three-wire
    int   len_tab [N_XFER] = '{8, 16, 32, 7, 13, 21, 8, 8, 24, 24};
    int   div_tab [N_XFER] = '{1, 2, 0, 1, 1, 2, 1, 1, 1, 1};
    int   mode_tab[N_XFER] = '{0, 0, 0, 1, 2, 3, 0, 0, 0, 0}; // {cpol, cpha}
    logic lsb_tab [N_XFER] = '{0, 0, 0, 1, 1, 1, 0, 0, 0, 0};
    logic man_tab [N_XFER] = '{0, 0, 0, 0, 0, 0, 1, 1, 0, 0};
    logic lvl_tab [N_XFER] = '{0, 0, 0, 0, 0, 0, 0, 1, 0, 0};
    logic dio_tab [N_XFER] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1};
    logic rd_tab  [N_XFER] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0};

    logic clk, reset, mem_valid, mem_ready, dio_en;
    spi_bus_pkg::bus_addr_t mem_addr;
    spi_bus_pkg::bus_data_t mem_wdata, mem_rdata;
    spi_bus_pkg::bus_strb_t mem_wstrb;
    logic spi_ss, spi_sck, spi_mosi, spi_oe;
    wire  spi_miso, spi_dio;

    logic [31:0] pat;          // Slave word
    logic        slave_bit;
    logic        cur_cpha, cur_lsb;
    logic [1:0]  status_mode;
    int cur_n, sck_edges, err_cnt, cycles, limit, failed, e0;
    int seed = 91274;

    assign spi_miso = slave_bit;
    assign spi_dio  = (spi_oe === 1'b0) ? slave_bit : 1'bz; // Slave drives after turnaround

    spi_dio_master i_dut (.*);

    spi_dio_checker i_chk (.*, .slave_pat(pat));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Bit on the wire after a given number of SCK edges
    function automatic logic slave_out(input int e);
        int idx;
        idx = (e < cur_cpha) ? 0 : (e - cur_cpha) / 2;
        if (idx >= cur_n) return 1'b0;
        return pat[cur_lsb ? idx : cur_n - 1 - idx];
    endfunction

    always @(spi_sck) begin
        sck_edges = sck_edges + 1;
        slave_bit = slave_out(sck_edges);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: transfers not finished after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // ----------------------------------------
    // CPU bus
    // ----------------------------------------
    task automatic bus_cycle(input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] s, output logic [31:0] q);
        @(posedge clk);
        mem_valid <= 1'b1;
        mem_addr  <= a;
        mem_wdata <= d;
        mem_wstrb <= s;
        do @(posedge clk); while (mem_ready !== 1'b1);
        q = mem_rdata;
        mem_valid <= 1'b0;
        mem_wstrb <= 4'h0;
    endtask

    task automatic run_transfer(input int k);
        logic [31:0] cw, tx, q;
        cur_n    = len_tab[k];
        cur_cpha = mode_tab[k][0];
        cur_lsb  = lsb_tab[k];
        pat = $random(seed);
        tx  = $random(seed);
        if (dio_tab[k]) tx[cur_n-1] = rd_tab[k]; // Read/write flag goes first
        cw = '0;
        cw[7:0]  = div_tab[k];
        cw[13:8] = cur_n[5:0];
        cw[16]   = mode_tab[k][1];
        cw[17]   = mode_tab[k][0];
        cw[18]   = cur_lsb;
        cw[25]   = man_tab[k];
        cw[26]   = lvl_tab[k];
        @(posedge clk);
        dio_en <= dio_tab[k];
        bus_cycle(CFG_A, cw, 4'hf, q);
        sck_edges = 0;
        slave_bit = slave_out(0);
        bus_cycle(DATA_A, tx, 4'hf, q);
        status_mode <= 2'b11; // Busy while shifting
        bus_cycle(CFG_A, 0, 4'h0, q);
        status_mode <= 2'b00;
        do bus_cycle(CFG_A, 0, 4'h0, q); while (q[30]);
        bus_cycle(DATA_A, 0, 4'h0, q);
        status_mode <= 2'b10;
        bus_cycle(CFG_A, 0, 4'h0, q);
        status_mode <= 2'b00;
    endtask

    task automatic end_test(input int num, input string name);
        if (err_cnt == e0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", num, name, err_cnt - e0);
            failed++;
        end
        e0 = err_cnt;
    endtask

    initial begin
        logic [31:0] q;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        dio_en    = 1'b0;
        reset     = 1'b1;
        status_mode = 2'b00;
        pat = '0;
        cur_n = 8;
        cur_cpha = 1'b0;
        cur_lsb  = 1'b0;
        sck_edges = 0;
        slave_bit = 1'b1;
        cycles = 0;
        failed = 0;
        e0 = 0;
        limit = 50;
        for (int k = 0; k < N_XFER; k++) limit += 2 * len_tab[k] * (div_tab[k] + 1) + 50;
        limit = 2 * limit;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        bus_cycle(CFG_A, $random(seed), 4'hf, q);
        status_mode <= 2'b10;
        bus_cycle(CFG_A, 0, 4'h0, q);
        status_mode <= 2'b00;
        end_test(1, "config readback");
        for (int k = 0; k < 3; k++) run_transfer(k);
        end_test(2, "four-wire mode 0");
        for (int k = 3; k < 6; k++) run_transfer(k);
        end_test(3, "modes 1 to 3 LSB first");
        for (int k = 6; k < 8; k++) run_transfer(k);
        end_test(4, "manual slave select");
        run_transfer(8);
        end_test(5, "three-wire read");
        run_transfer(9);
        end_test(6, "three-wire write");
        $display("tests 6, failed %0d, errors %0d", failed, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/spi_dio_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_dio_cfg.svh"

module spi_dio_checker (
    input  wire        clk,
    input  wire        reset,
    input  wire        mem_valid,
    input  wire [31:0] mem_addr,
    input  wire [31:0] mem_wdata,
    input  wire [3:0]  mem_wstrb,
    input  wire        mem_ready,
    input  wire [31:0] mem_rdata,
    input  wire        spi_ss,
    input  wire        spi_sck,
    input  wire        spi_mosi,
    input  wire        spi_miso,
    input  wire        dio_en,
    input  wire        spi_dio,
    input  wire        spi_oe,
    input  wire [31:0] slave_pat,   // Word the slave model shifts out
    input  wire [1:0]  status_mode, // Bit 1 set means check busy against bit 0
    output int         err_cnt
);

    localparam logic [31:0] DATA_A = `SPI_DIO_BASE_ADDR + `SPI_DIO_REG_DATA;
    localparam logic [31:0] CFG_A  = `SPI_DIO_BASE_ADDR + `SPI_DIO_REG_CFG;

    spi_reg_pkg::spi_cfg_t  cfg_q;  // Last configuration written
    spi_reg_pkg::spi_word_t tx_q;   // Last word sent
    int   edges, bit_cnt, post_cnt, n;
    logic sck_q, miso_q, sel;
    logic cfg_wr; // Idle SCK level may move with this write
    logic rdy_q;  // mem_ready one clock ago
    logic req_q;  // Fresh request one clock ago
    logic mosi_bits [0:31];
    logic dio_bits  [0:31];
    logic oe_bits   [0:31];

    initial err_cnt = 0;

    // Length rule, 0 and above 32 mean a full word
    function automatic int eff_len(input logic [5:0] nb);
        return (nb == 0 || nb > 32) ? 32 : int'(nb);
    endfunction

    // Bit i on the wire for a word of length len
    function automatic logic wire_bit(input logic [31:0] w, input int len,
                                      input logic lsb, input int i);
        return lsb ? w[i] : w[len-1-i];
    endfunction

    // ----------------------------------------
    // Reference model of the received word
    // ----------------------------------------
    function automatic logic [31:0] expected_rx(input logic [31:0] tx, input logic [31:0] pat,
                                                input int len, input logic lsb,
                                                input logic three);
        logic [31:0] rx;
        logic        rd;
        logic        from_slave;
        int          pos;
        rx = '0;
        rd = three && wire_bit(tx, len, lsb, 0); // Read flag is the first bit out
        for (int i = 0; i < len; i++) begin
            pos        = lsb ? i : len - 1 - i;
            from_slave = !three || (rd && i >= len - `SPI_DIO_DATA_BITS);
            rx[pos]    = from_slave ? pat[pos] : tx[pos]; // Pin echoes our own MOSI
        end
        return rx;
    endfunction

    task automatic flag_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic check_status();
        if (mem_rdata[29:0] !== cfg_q.raw[29:0])
            flag_error($sformatf("cfg read %h, written %h", mem_rdata[29:0], cfg_q.raw[29:0]));
        if (status_mode[1] && mem_rdata[30] !== status_mode[0])
            flag_error($sformatf("busy bit %b, expected %b", mem_rdata[30], status_mode[0]));
        if (mem_rdata[31] !== miso_q)
            flag_error($sformatf("miso bit %b, pin was %b", mem_rdata[31], miso_q));
    endtask

    task automatic check_frame();
        logic [31:0] exp;
        logic        rd;
        logic        exp_oe;
        logic        lsb;
        lsb = cfg_q.f.lsb_first;
        exp = expected_rx(tx_q, slave_pat, n, lsb, dio_en);
        rd  = dio_en && wire_bit(tx_q, n, lsb, 0);
        if (mem_rdata !== exp)
            flag_error($sformatf("rx_word %h, expected %h", mem_rdata, exp));
        if (bit_cnt != n)
            flag_error($sformatf("%0d bits clocked, expected %0d", bit_cnt, n));
        for (int i = 0; i < n && i < bit_cnt; i++) begin
            if (mosi_bits[i] !== wire_bit(tx_q, n, lsb, i))
                flag_error($sformatf("mosi bit %0d is %b", i, mosi_bits[i]));
            exp_oe = !(rd && i >= n - `SPI_DIO_DATA_BITS); // Slave owns the tail of a read
            if (dio_en && oe_bits[i] !== exp_oe)
                flag_error($sformatf("spi_oe %b at bit %0d", oe_bits[i], i));
            if (dio_en && exp_oe && dio_bits[i] !== wire_bit(tx_q, n, lsb, i))
                flag_error($sformatf("spi_dio bit %0d is %b", i, dio_bits[i]));
        end
        if (spi_sck !== cfg_q.f.cpol)
            flag_error($sformatf("spi_sck idles at %b", spi_sck));
    endtask

    // ----------------------------------------
    // Bus and pin monitor
    // ----------------------------------------
    always @(posedge clk) begin
        sel    = dio_en ? spi_dio : spi_miso; // Same pick as the top level
        cfg_wr = 1'b0;
        if (!reset) begin
            // Ready answers the first request cycle, for one clock only
            if (mem_ready && (rdy_q || !req_q))
                flag_error("mem_ready is not a single pulse after the request");
            if (mem_valid && mem_ready && mem_addr == CFG_A) begin
                if (mem_wstrb != 0) begin
                    cfg_q.raw = mem_wdata;
                    cfg_wr    = 1'b1; // SCK jumps to the new idle level here
                end else begin
                    check_status();
                end
            end
            n = eff_len(cfg_q.f.nbits);
            if (mem_valid && mem_ready && mem_addr == DATA_A) begin
                if (mem_wstrb != 0) begin
                    tx_q     = mem_wdata; // New frame
                    edges    = 0;
                    bit_cnt  = 0;
                    post_cnt = 0;
                    if (spi_sck !== cfg_q.f.cpol)
                        flag_error($sformatf("spi_sck idles at %b", spi_sck));
                end else begin
                    check_frame();
                end
            end
            if (spi_sck !== sck_q && !cfg_wr) begin
                edges++;
                // Leading edges sample in phase 0, trailing in phase 1
                if (((spi_sck != cfg_q.f.cpol) ^ cfg_q.f.cpha) && bit_cnt < 32) begin
                    mosi_bits[bit_cnt] = spi_mosi;
                    dio_bits[bit_cnt]  = spi_dio;
                    oe_bits[bit_cnt]   = spi_oe;
                    bit_cnt++;
                    if (cfg_q.f.ss_manual && spi_ss !== cfg_q.f.ss_level)
                        flag_error($sformatf("spi_ss %b, ss_level %b", spi_ss, cfg_q.f.ss_level));
                    if (!cfg_q.f.ss_manual && spi_ss !== 1'b0)
                        flag_error("spi_ss high during a transfer");
                end
            end
            if (edges == 2 * n) post_cnt++;
            if (post_cnt == 4 && !cfg_q.f.ss_manual && spi_ss !== 1'b1)
                flag_error("spi_ss still low after the transfer");
        end
        sck_q  = spi_sck;
        miso_q = sel;
        rdy_q  = mem_ready;
        req_q  = mem_valid && !mem_ready;
    end

endmodule

`default_nettype wire

// ==== hdl/spi_dio_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_dio_master (
    input  wire                         clk,
    input  wire                         reset,
    // CPU bus
    input  wire                         mem_valid,
    input  wire spi_bus_pkg::bus_addr_t mem_addr,
    input  wire spi_bus_pkg::bus_data_t mem_wdata,
    input  wire spi_bus_pkg::bus_strb_t mem_wstrb,
    output logic                        mem_ready,
    output spi_bus_pkg::bus_data_t      mem_rdata,
    // SPI pins
    output logic                        spi_ss,
    output logic                        spi_sck,
    output logic                        spi_mosi,
    input  wire                         spi_miso,
    input  wire                         dio_en,   // 1 = three-wire slave
    inout  wire                         spi_dio,
    output logic                        spi_oe
);

    logic                   start;
    spi_reg_pkg::spi_word_t tx_word;
    spi_reg_pkg::spi_word_t rx_word;
    spi_reg_pkg::spi_cfg_t  cfg;
    logic                   busy;
    logic                   ss_auto;
    logic                   dio_in;   // Value seen on the shared pin
    logic                   miso_sel;

    // ----------------------------------------
    // Pin selection
    // ----------------------------------------
    assign miso_sel = dio_en ? dio_in : spi_miso;                 // Receive source
    assign spi_ss   = cfg.f.ss_manual ? cfg.f.ss_level : ss_auto; // Manual or auto SS

    spi_sfr_bank i_bank (
        .clk        (clk),
        .reset      (reset),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wstrb  (mem_wstrb),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .rx_word    (rx_word),
        .busy       (busy),
        .miso_state (miso_sel),
        .start      (start),
        .tx_word    (tx_word),
        .cfg        (cfg)
    );

    spi_shift_engine i_engine (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .tx_word (tx_word),
        .cfg     (cfg),
        .miso    (miso_sel),
        .rx_word (rx_word),
        .busy    (busy),
        .ss_auto (ss_auto),
        .sck     (spi_sck),
        .mosi    (spi_mosi)
    );

    // Works on the final SS, so manual framing also turns the pin around
    spi_dio_bridge i_bridge (
        .clk    (clk),
        .ss     (spi_ss),
        .sck    (spi_sck),
        .mosi   (spi_mosi),
        .nbits  (cfg.f.nbits),
        .oe     (spi_oe),
        .dio    (spi_dio),
        .dio_in (dio_in)
    );

endmodule

`default_nettype wire

// ==== hdl/spi_dio_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_dio_cfg.svh"

// Direction control for a three-wire slave, mode 0 only
module spi_dio_bridge #(
    parameter int DATA_BITS = `SPI_DIO_DATA_BITS
) (
    input  wire                          clk,
    input  wire                          ss,
    input  wire                          sck,
    input  wire                          mosi,
    input  wire spi_reg_pkg::spi_nbits_t nbits,
    output logic                         oe,
    inout  wire                          dio,
    output logic                         dio_in
);

    localparam spi_reg_pkg::spi_nbits_t DATA_LEN = spi_reg_pkg::spi_nbits_t'(DATA_BITS);
    localparam spi_reg_pkg::spi_nbits_t RW_POS   = spi_reg_pkg::spi_nbits_t'(`SPI_DIO_RW_BIT);

    logic                    sck_d;     // SCK one clock ago
    logic                    sck_rise;
    logic                    sck_fall;
    spi_reg_pkg::spi_nbits_t fall_cnt;  // Falling edges in this frame
    logic                    write_q;   // Keep driving, frame is a write
    spi_reg_pkg::spi_nbits_t instr_len; // Bits sent before turnaround
    logic                    release_now;

    assign sck_rise = !sck_d && sck;
    assign sck_fall = sck_d && !sck;

    // Instruction part of the frame
    assign instr_len = spi_reg_pkg::spi_eff_nbits(nbits) - DATA_LEN;

    always_ff @(posedge clk) begin
        sck_d <= sck;
        if (ss) begin
            fall_cnt <= '0;   // Idle frame, drive the pin
            write_q  <= 1'b1;
        end else begin
            fall_cnt <= fall_cnt + {5'd0, sck_fall};
            // A 1 in the RW slot hands the data part to the slave
            if (sck_rise && fall_cnt == RW_POS) begin
                write_q <= !mosi;
            end
        end
    end

    // Let go on the last instruction falling edge itself
    assign release_now = sck_fall && (fall_cnt == instr_len - 6'd1);
    assign oe          = write_q || ((fall_cnt < instr_len) && !release_now);

    assign dio    = oe ? mosi : 1'bz;
    assign dio_in = dio;

endmodule

`default_nettype wire

// ==== hdl/spi_shift_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         start,   // One cycle, ignored while busy
    input  wire spi_reg_pkg::spi_word_t tx_word,
    input  wire spi_reg_pkg::spi_cfg_t  cfg,
    input  wire                         miso,
    output spi_reg_pkg::spi_word_t      rx_word, // Right aligned
    output logic                        busy,
    output logic                        ss_auto,
    output logic                        sck,
    output logic                        mosi
);

    // Settings frozen for the whole transfer
    logic [7:0]              div_q;
    spi_reg_pkg::spi_nbits_t n_q;
    logic                    cpol_q;
    logic                    cpha_q;
    logic                    lsb_q;

    logic [7:0]              div_cnt;   // Cycles left in this half period
    logic [6:0]              edge_cnt;  // SCK edges done so far
    logic                    sck_phase; // 1 while SCK is off its idle level
    logic                    tail;      // Hold cycle after the last edge

    spi_reg_pkg::spi_word_t  tx_sr;     // Outgoing bits, next one at the end
    spi_reg_pkg::spi_word_t  rx_sr;     // Incoming bits

    spi_reg_pkg::spi_nbits_t n_load;    // Length taken at start
    spi_reg_pkg::spi_nbits_t rx_shift;  // Realign amount for LSB first
    logic [6:0]              edge_next;
    logic                    sample_now;
    logic                    launch_now;
    spi_reg_pkg::spi_word_t  rx_final;

    assign n_load = spi_reg_pkg::spi_eff_nbits(cfg.f.nbits);

    // ----------------------------------------
    // Edge classification
    // ----------------------------------------
    // Odd edges lead, even edges trail
    assign edge_next  = edge_cnt + 7'd1;
    assign sample_now = edge_next[0] ^ cpha_q;            // Mode 0/2 lead, 1/3 trail
    assign launch_now = !sample_now && (edge_next != 7'd1); // First bit is preloaded

    // LSB first fills from the top, move it down to bit 0
    assign rx_shift = 6'd32 - n_q;
    assign rx_final = lsb_q ? (rx_sr >> rx_shift) : rx_sr;

    // ----------------------------------------
    // Pins
    // ----------------------------------------
    assign ss_auto = !busy;                                // Active low for the transfer
    assign sck     = (busy ? cpol_q : cfg.f.cpol) ^ sck_phase; // Idles at cpol
    assign mosi    = lsb_q ? tx_sr[0] : tx_sr[31];

    // ----------------------------------------
    // Sequencer and shift registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            tail      <= 1'b0;
            sck_phase <= 1'b0;
            div_cnt   <= '0;
            edge_cnt  <= '0;
            div_q     <= '0;
            n_q       <= '0;
            cpol_q    <= 1'b0;
            cpha_q    <= 1'b0;
            lsb_q     <= 1'b0;
            tx_sr     <= '0;
            rx_sr     <= '0;
            rx_word   <= '0;
        end else if (!busy) begin
            if (start) begin
                busy     <= 1'b1;
                tail     <= 1'b0;
                div_cnt  <= cfg.f.clk_div;
                edge_cnt <= '0;
                div_q    <= cfg.f.clk_div;
                n_q      <= n_load;
                cpol_q   <= cfg.f.cpol;
                cpha_q   <= cfg.f.cpha;
                lsb_q    <= cfg.f.lsb_first;
                rx_sr    <= '0;
                // Line the first bit up on the shift-out end
                if (cfg.f.lsb_first) begin
                    tx_sr <= tx_word;
                end else begin
                    tx_sr <= tx_word << (6'd32 - n_load);
                end
            end
        end else if (tail) begin
            busy    <= 1'b0;     // SS goes back up here
            tail    <= 1'b0;
            rx_word <= rx_final;
        end else if (div_cnt == 8'd0) begin
            div_cnt   <= div_q;  // Next half period
            sck_phase <= !sck_phase;
            edge_cnt  <= edge_next;
            if (sample_now) begin
                if (lsb_q) begin
                    rx_sr <= {miso, rx_sr[31:1]};
                end else begin
                    rx_sr <= {rx_sr[30:0], miso};
                end
            end
            if (launch_now) begin
                if (lsb_q) begin
                    tx_sr <= {1'b0, tx_sr[31:1]};
                end else begin
                    tx_sr <= {tx_sr[30:0], 1'b0};
                end
            end
            // SCK is back at idle after 2n edges
            if (edge_next == {n_q, 1'b0}) begin
                tail <= 1'b1;
            end
        end else begin
            div_cnt <= div_cnt - 8'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_sfr_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_dio_cfg.svh"

module spi_sfr_bank (
    input  wire                     clk,
    input  wire                     reset,
    // CPU bus
    input  wire                     mem_valid,
    input  wire spi_bus_pkg::bus_addr_t mem_addr,
    input  wire spi_bus_pkg::bus_data_t mem_wdata,
    input  wire spi_bus_pkg::bus_strb_t mem_wstrb,
    output logic                    mem_ready,
    output spi_bus_pkg::bus_data_t  mem_rdata,
    // Engine side
    input  wire spi_reg_pkg::spi_word_t rx_word,
    input  wire                     busy,
    input  wire                     miso_state,
    output logic                    start,
    output spi_reg_pkg::spi_word_t  tx_word,
    output spi_reg_pkg::spi_cfg_t   cfg
);

    logic hit_data; // Access to the data word
    logic hit_cfg;  // Access to the config word
    logic acc;      // First cycle of a matching access
    logic wr;       // Any byte written

    // Merge the strobed byte lanes into the old word
    function automatic spi_bus_pkg::bus_data_t apply_strb(
        input spi_bus_pkg::bus_data_t old_word,
        input spi_bus_pkg::bus_data_t new_word,
        input spi_bus_pkg::bus_strb_t strb
    );
        spi_bus_pkg::bus_data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign hit_data = mem_valid && (mem_addr == `SPI_DIO_BASE_ADDR + `SPI_DIO_REG_DATA);
    assign hit_cfg  = mem_valid && (mem_addr == `SPI_DIO_BASE_ADDR + `SPI_DIO_REG_CFG);

    // CPU keeps valid up while ready is high, so ignore that cycle
    assign acc = (hit_data || hit_cfg) && !mem_ready;
    assign wr  = |mem_wstrb;

    // ----------------------------------------
    // Registers and acknowledge
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            start     <= 1'b0;
            tx_word   <= '0;
            cfg.raw   <= '0;
        end else begin
            mem_ready <= acc;                                 // One cycle ack
            start     <= acc && hit_data && mem_wstrb[0];     // Low byte kicks off
            if (acc && wr && hit_data) begin
                tx_word <= apply_strb(tx_word, mem_wdata, mem_wstrb);
            end
            if (acc && wr && hit_cfg) begin
                cfg.raw <= apply_strb(cfg.raw, mem_wdata, mem_wstrb);
            end
            // Read mux, status bits replace the top of the config word
            if (acc) begin
                if (hit_cfg) begin
                    mem_rdata <= {miso_state, busy, cfg.raw[29:0]};
                end else begin
                    mem_rdata <= rx_word; // Last complete reception
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_bus_pkg.sv ====
`default_nettype none

// ----------------------------------------
// Native memory bus of the soft CPU
// ----------------------------------------
// valid is held by the CPU until ready
// comes back for one cycle, wstrb of zero
// marks a read

package spi_bus_pkg;

    // Byte address, only word aligned accesses are decoded
    typedef logic [31:0] bus_addr_t;

    // Write data towards the slave and read data back
    typedef logic [31:0] bus_data_t;

    // One strobe per byte lane, bit 0 is bits 7:0
    typedef logic [3:0]  bus_strb_t;

endpackage

`default_nettype wire

// ==== hdl/spi_reg_pkg.sv ====
`default_nettype none

package spi_reg_pkg;

    typedef logic [31:0] spi_word_t;  // One transfer word, right aligned
    typedef logic [5:0]  spi_nbits_t; // Bits per transfer

    // Field view of the configuration register, MSB first
    typedef struct packed {
        logic       miso;        // 31, pin state, read only
        logic       busy;        // 30, engine busy, read only
        logic [2:0] rsvd_29_27;
        logic       ss_level;    // 26, SS level in manual mode
        logic       ss_manual;   // 25, 1 = firmware owns SS
        logic [5:0] rsvd_24_19;
        logic       lsb_first;   // 18
        logic       cpha;        // 17, 1 = sample on trailing edge
        logic       cpol;        // 16, idle level of SCK
        logic [1:0] rsvd_15_14;
        spi_nbits_t nbits;       // 13:8, 0 means 32
        logic [7:0] clk_div;     // 7:0, half period minus one
    } spi_cfg_fields_t;

    // Bus side sees a raw word, the datapath sees fields
    typedef union packed {
        spi_word_t       raw;
        spi_cfg_fields_t f;
    } spi_cfg_t;

    // Length actually shifted, 0 and anything above 32 run a full word
    function automatic spi_nbits_t spi_eff_nbits(input spi_nbits_t nbits);
        spi_nbits_t n;
        n = nbits;
        if (n == 6'd0 || n > 6'd32) begin
            n = 6'd32;
        end
        return n;
    endfunction

endpackage

`default_nettype wire

// ==== include/spi_dio_cfg.svh ====
`ifndef SPI_DIO_CFG_SVH
`define SPI_DIO_CFG_SVH

// ----------------------------------------
// Address map of the SPI master
// ----------------------------------------

// Word address of the data register
`define SPI_DIO_BASE_ADDR 32'h0300_0100

// Register offsets from the base address
`define SPI_DIO_REG_DATA 32'd0 // Data, write to send and read last word
`define SPI_DIO_REG_CFG  32'd4 // Configuration and status

// ----------------------------------------
// Three-wire turnaround
// ----------------------------------------

// Trailing bits that a three-wire read hands over to the slave
`define SPI_DIO_DATA_BITS 8

// Position of the read/write flag, first bit on the wire
`define SPI_DIO_RW_BIT 0

`endif
